/* run.sh */
#!/bin/sh
# Build and run the CSR path testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
	--top-module csr_unit_tb -Mdir obj_dir -o csr_unit_sim -f tb.f

./obj_dir/csr_unit_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^TEST OK$" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi

/* source/csr_decode.sv */
//////////////////////////////////////////////////////////////////////
// CSR decode. Picks Zicsr instructions out of the instruction strobe
// and pushes them into the issue queue one cycle later.
// The queue has no back-pressure. Pushes beyond FIFO_DEPTH are
// caught by an assertion on a local occupancy count.
//////////////////////////////////////////////////////////////////////
`default_nettype none

module csr_decode import csr_pkg::*; #(
	parameter int FIFO_DEPTH = 4
) (
	input  logic CLK,
	input  logic rst_n,
	input  logic flush,
	input  logic instr_valid,
	input  logic [31:0] instr,
	input  logic [xlen-1:0] instr_pc,
	input  logic pop,
	output logic push,
	output issue_info_t entry
);

	localparam logic [6:0] opc_system = 7'b1110011;
	localparam int CW = $clog2(FIFO_DEPTH) + 1;

	logic is_csr;
	csr_op_t dec_op;
	logic [CW-1:0] q_count;

	// funct3[1:0] selects the operation, funct3[2] the immediate form
	always_comb begin
		is_csr = (instr[6:0] == opc_system);
		dec_op = op_rw;
		case (instr[13:12])
			2'd1: dec_op = op_rw;
			2'd2: dec_op = op_rs;
			2'd3: dec_op = op_rc;
			default: is_csr = 1'b0;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			push <= 1'b0;
		end else begin
			push <= instr_valid && is_csr;
		end
	end

	always_ff @(posedge CLK) begin
		if (instr_valid && is_csr) begin
			entry.op <= dec_op;
			entry.imm_form <= instr[14];
			entry.pc <= instr_pc;
			entry.addr <= instr[31:20];
			entry.rd <= instr[11:7];
			entry.rs1 <= instr[19:15];
		end
	end

	// Mirror of the queue occupancy
	always_ff @(posedge CLK) begin
		if (!rst_n || flush) begin
			q_count <= '0;
		end else begin
			q_count <= q_count + {{(CW-1){1'b0}}, push} - {{(CW-1){1'b0}}, pop};
		end
	end

	assert property (@(posedge CLK) disable iff (!rst_n || flush)
		push |-> (q_count < FIFO_DEPTH) || pop)
		else $error("CSR issue queue overflow");

endmodule

`default_nettype wire

/* source/csr_execute.sv */
//////////////////////////////////////////////////////////////////////
// Machine CSR file with read-modify-write
// Holds mscratch, mepc, mcause and mtval. Other addresses read zero
// and drop writes. No privilege checks and no side effects.
// The old CSR value is the result, reported only when rd is not x0.
//////////////////////////////////////////////////////////////////////
`default_nettype none

module csr_execute import csr_pkg::*; (
	input  logic CLK,
	input  logic rst_n,
	input  logic exe_valid,
	input  exe_param_t exe_param,
	output logic res_valid,
	output wb_t res
);

	logic [xlen-1:0] mscratch;
	logic [xlen-1:0] mepc;
	logic [xlen-1:0] mcause;
	logic [xlen-1:0] mtval;

	logic [xlen-1:0] csr_old;
	logic [xlen-1:0] csr_new;
	logic csr_we;

	always_comb begin
		case (exe_param.addr)
			csr_mscratch: csr_old = mscratch;
			csr_mepc: csr_old = mepc;
			csr_mcause: csr_old = mcause;
			csr_mtval: csr_old = mtval;
			default: csr_old = '0;
		endcase
	end

	always_comb begin
		case (exe_param.op)
			op_rw: csr_new = exe_param.operand;
			op_rs: csr_new = csr_old | exe_param.operand;
			op_rc: csr_new = csr_old & ~exe_param.operand;
			default: csr_new = csr_old;
		endcase
	end

	// Set and clear with a zero operand leave the CSR alone
	assign csr_we = exe_valid && ((exe_param.op == op_rw) || (exe_param.operand != '0));

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			mscratch <= '0;
			mepc <= '0;
			mcause <= '0;
			mtval <= '0;
		end else if (csr_we) begin
			case (exe_param.addr)
				csr_mscratch: mscratch <= csr_new;
				csr_mepc: mepc <= csr_new;
				csr_mcause: mcause <= csr_new;
				csr_mtval: mtval <= csr_new;
				default: ;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			res_valid <= 1'b0;
		end else begin
			res_valid <= exe_valid && (exe_param.rd != '0);
		end
	end

	always_ff @(posedge CLK) begin
		if (exe_valid) begin
			res.rd <= exe_param.rd;
			res.data <= csr_old;
		end
	end

	assert property (@(posedge CLK) disable iff (!rst_n)
		exe_valid |-> exe_param.op inside {op_rw, op_rs, op_rc})
		else $error("illegal CSR operation code");

endmodule

`default_nettype wire

/* source/csr_issue.sv */
//////////////////////////////////////////////////////////////////////
// CSR issue. The oldest queued instruction leaves only when commit_pc
// has reached its pc and its rs1 has been written back.
// rd must also be written back by any earlier writer, and rd is
// marked pending at pop. Without renaming this keeps RAW, WAR and WAW
// order. Execute is always ready.
//////////////////////////////////////////////////////////////////////
`default_nettype none

module csr_issue import csr_pkg::*; (
	input  logic CLK,
	input  logic rst_n,
	input  logic flush,
	input  issue_info_t head,
	input  logic empty,
	input  logic [xlen-1:0] commit_pc,
	input  logic [31:0][xlen-1:0] reg_file,
	input  logic [31:0] wb_log,
	output logic pop,
	output logic alloc_valid,
	output reg_idx_t alloc_rd,
	output logic exe_valid,
	output exe_param_t exe_param
);

	logic in_order;
	logic rs1_ready;
	logic rd_free;
	logic issue_go;
	logic [xlen-1:0] operand;

	// All older instructions have committed
	assign in_order = (commit_pc == head.pc);

	// Immediate forms carry zimm in rs1 and need no register
	assign rs1_ready = head.imm_form || wb_log[head.rs1];
	assign rd_free = wb_log[head.rd];

	assign issue_go = !empty && !flush && in_order && rs1_ready && rd_free;
	assign pop = issue_go;

	// x0 never goes pending
	assign alloc_valid = issue_go && (head.rd != '0);
	assign alloc_rd = head.rd;

	assign operand = head.imm_form ? {{(xlen-5){1'b0}}, head.rs1} : reg_file[head.rs1];

	always_ff @(posedge CLK) begin
		if (!rst_n || flush) begin
			exe_valid <= 1'b0;
			exe_param <= '0;
		end else begin
			exe_valid <= issue_go;
			if (issue_go) begin
				exe_param.op <= head.op;
				exe_param.rd <= head.rd;
				exe_param.operand <= operand;
				exe_param.addr <= head.addr;
			end
		end
	end

endmodule

`default_nettype wire

/* source/csr_issue_fifo.sv */
//////////////////////////////////////////////////////////////////////
// In-order issue queue with flush
// FIFO_DEPTH must be a power of two and at least 2. There is no full
// output, the producer keeps its own count.
// Flush wins over a push in the same cycle.
//////////////////////////////////////////////////////////////////////
`default_nettype none

module csr_issue_fifo #(
	parameter type entry_t = logic [7:0],
	parameter int FIFO_DEPTH = 4
) (
	input  logic CLK,
	input  logic rst_n,
	input  logic flush,
	input  logic push,
	input  entry_t push_entry,
	input  logic pop,
	output entry_t head,
	output logic empty
);

	localparam int AW = $clog2(FIFO_DEPTH);

	entry_t mem [FIFO_DEPTH];

	// Extra top bit separates full from empty
	logic [AW:0] wptr;
	logic [AW:0] rptr;

	assign empty = (wptr == rptr);
	assign head = mem[rptr[AW-1:0]];

	always_ff @(posedge CLK) begin
		if (!rst_n || flush) begin
			wptr <= '0;
			rptr <= '0;
		end else begin
			if (push) begin
				wptr <= wptr + 1'b1;
			end
			if (pop) begin
				rptr <= rptr + 1'b1;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (push && !flush) begin
			mem[wptr[AW-1:0]] <= push_entry;
		end
	end

	assert property (@(posedge CLK) disable iff (!rst_n) pop |-> !empty)
		else $error("pop from an empty CSR issue queue");

endmodule

`default_nettype wire

/* source/csr_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Shared types for the CSR path of the RV64 core
// Register indices are architectural (5 bits) since there is no
// renaming. Only four machine CSRs are implemented.
//////////////////////////////////////////////////////////////////////
`default_nettype none

package csr_pkg;

	localparam int xlen = 64;

	typedef logic [4:0] reg_idx_t;
	typedef logic [11:0] csr_addr_t;

	// Implemented machine CSRs
	localparam csr_addr_t csr_mscratch = 12'h340;
	localparam csr_addr_t csr_mepc = 12'h341;
	localparam csr_addr_t csr_mcause = 12'h342;
	localparam csr_addr_t csr_mtval = 12'h343;

	typedef enum logic [1:0] {
		op_rw = 2'd0,
		op_rs = 2'd1,
		op_rc = 2'd2
	} csr_op_t;

	// Queued CSR instruction, rs1 holds zimm for immediate forms
	typedef struct packed {
		csr_op_t op;
		logic imm_form;
		logic [xlen-1:0] pc;
		csr_addr_t addr;
		reg_idx_t rd;
		reg_idx_t rs1;
	} issue_info_t;

	// Issue to execute
	typedef struct packed {
		csr_op_t op;
		reg_idx_t rd;
		logic [xlen-1:0] operand;
		csr_addr_t addr;
	} exe_param_t;

	// Register writeback
	typedef struct packed {
		reg_idx_t rd;
		logic [xlen-1:0] data;
	} wb_t;

endpackage

`default_nettype wire

/* source/csr_result.sv */
//////////////////////////////////////////////////////////////////////
// Integer register file with its written-back log
// x0 reads zero and stays ready. On a same-cycle write to one
// register the CSR result wins over the external writeback, and a
// new pending mark wins over both.
//////////////////////////////////////////////////////////////////////
`default_nettype none

module csr_result import csr_pkg::*; (
	input  logic CLK,
	input  logic rst_n,
	input  logic res_valid,
	input  wb_t res,
	input  logic ext_wb_valid,
	input  wb_t ext_wb,
	input  logic alloc_valid,
	input  reg_idx_t alloc_rd,
	output logic [31:0][xlen-1:0] reg_file,
	output logic [31:0] wb_log,
	output logic wb_valid,
	output wb_t wb
);

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			reg_file <= '0;
			wb_log <= '1;
		end else begin
			if (ext_wb_valid && (ext_wb.rd != '0)) begin
				reg_file[ext_wb.rd] <= ext_wb.data;
				wb_log[ext_wb.rd] <= 1'b1;
			end
			// Later assignment takes priority
			if (res_valid) begin
				reg_file[res.rd] <= res.data;
				wb_log[res.rd] <= 1'b1;
			end
			if (alloc_valid && (alloc_rd != '0)) begin
				wb_log[alloc_rd] <= 1'b0;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			wb_valid <= 1'b0;
		end else begin
			wb_valid <= res_valid;
		end
	end

	always_ff @(posedge CLK) begin
		if (res_valid) begin
			wb <= res;
		end
	end

	// Execute filters x0 results
	assert property (@(posedge CLK) disable iff (!rst_n) res_valid |-> (res.rd != '0))
		else $error("CSR result targets x0");

endmodule

`default_nettype wire

/* source/csr_unit.sv */
//////////////////////////////////////////////////////////////////////
// CSR path top level
// commit_pc must sit at a CSR instruction's pc until it issues.
// Minimum latency from instruction strobe to wb_valid is five cycles.
// Flush drops queued instructions but not those already executing.
// No back-pressure on any interface.
//////////////////////////////////////////////////////////////////////
`default_nettype none

module csr_unit import csr_pkg::*; #(
	parameter int FIFO_DEPTH = 4
) (
	input  logic CLK,
	input  logic rst_n,
	input  logic instr_valid,
	input  logic [31:0] instr,
	input  logic [xlen-1:0] instr_pc,
	input  logic [xlen-1:0] commit_pc,
	input  logic flush,
	input  logic ext_wb_valid,
	input  wb_t ext_wb,
	output logic wb_valid,
	output wb_t wb
);

	logic push;
	issue_info_t entry;
	issue_info_t head;
	logic empty;
	logic pop;
	logic alloc_valid;
	reg_idx_t alloc_rd;
	logic exe_valid;
	exe_param_t exe_param;
	logic res_valid;
	wb_t res;
	logic [31:0][xlen-1:0] reg_file;
	logic [31:0] wb_log;

	csr_decode #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_decode (
		.CLK(CLK),
		.rst_n(rst_n),
		.flush(flush),
		.instr_valid(instr_valid),
		.instr(instr),
		.instr_pc(instr_pc),
		.pop(pop),
		.push(push),
		.entry(entry)
	);

	csr_issue_fifo #(
		.entry_t(issue_info_t),
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_fifo (
		.CLK(CLK),
		.rst_n(rst_n),
		.flush(flush),
		.push(push),
		.push_entry(entry),
		.pop(pop),
		.head(head),
		.empty(empty)
	);

	csr_issue u_issue (
		.CLK(CLK),
		.rst_n(rst_n),
		.flush(flush),
		.head(head),
		.empty(empty),
		.commit_pc(commit_pc),
		.reg_file(reg_file),
		.wb_log(wb_log),
		.pop(pop),
		.alloc_valid(alloc_valid),
		.alloc_rd(alloc_rd),
		.exe_valid(exe_valid),
		.exe_param(exe_param)
	);

	csr_execute u_execute (
		.CLK(CLK),
		.rst_n(rst_n),
		.exe_valid(exe_valid),
		.exe_param(exe_param),
		.res_valid(res_valid),
		.res(res)
	);

	csr_result u_result (
		.CLK(CLK),
		.rst_n(rst_n),
		.res_valid(res_valid),
		.res(res),
		.ext_wb_valid(ext_wb_valid),
		.ext_wb(ext_wb),
		.alloc_valid(alloc_valid),
		.alloc_rd(alloc_rd),
		.reg_file(reg_file),
		.wb_log(wb_log),
		.wb_valid(wb_valid),
		.wb(wb)
	);

endmodule

`default_nettype wire

/* tb.f */
source/csr_pkg.sv
source/csr_decode.sv
source/csr_issue_fifo.sv
source/csr_issue.sv
source/csr_execute.sv
source/csr_result.sv
source/csr_unit.sv
tb/csr_unit_checker.sv
tb/csr_unit_tb.sv

/* tb/csr_unit_checker.sv */
//////////////////////////////////////////////////////////////////////
// Writeback checker for the CSR path
// Models the CSR file, register file and issue queue from the DUT
// inputs only. An instruction retires in the model when commit_pc
// matches the oldest queued pc, so every row must hold commit_pc
// long enough to issue.
//////////////////////////////////////////////////////////////////////
`default_nettype none

module csr_unit_checker import csr_pkg::*; (
	input  logic CLK,
	input  logic rst_n,
	input  logic instr_valid,
	input  logic [31:0] instr,
	input  logic [xlen-1:0] instr_pc,
	input  logic [xlen-1:0] commit_pc,
	input  logic flush,
	input  logic ext_wb_valid,
	input  wb_t ext_wb,
	input  logic wb_valid,
	input  wb_t wb,
	input  logic done,
	output int errors,
	output int outstanding
);

	timeunit 1ns;
	timeprecision 1ps;

	logic [xlen-1:0] csr_model [4];
	logic [xlen-1:0] reg_model [32];
	logic [31:0] queued_instr [$];
	logic [xlen-1:0] queued_pc [$];
	wb_t expected [$];
	int err_count = 0;
	int n_pending = 0;
	logic reported = 1'b0;

	assign errors = err_count;
	assign outstanding = n_pending;

	// SYSTEM opcode with funct3 other than 0 and 4
	function automatic logic is_csr(input logic [31:0] iw);
		return (iw[6:0] == 7'b1110011) && (iw[13:12] != 2'b00);
	endfunction

	task automatic retire(input logic [31:0] iw);
		csr_addr_t addr;
		reg_idx_t rs1;
		reg_idx_t rd;
		logic known;
		logic [xlen-1:0] operand;
		logic [xlen-1:0] old_val;
		logic [xlen-1:0] new_val;
		addr = iw[31:20];
		rs1 = iw[19:15];
		rd = iw[11:7];
		known = (addr >= csr_mscratch) && (addr <= csr_mtval);
		operand = iw[14] ? {{(xlen-5){1'b0}}, rs1} : reg_model[rs1];
		old_val = known ? csr_model[addr[1:0]] : '0;
		case (iw[13:12])
			2'd1: new_val = operand;
			2'd2: new_val = old_val | operand;
			default: new_val = old_val & ~operand;
		endcase
		if (known && ((iw[13:12] == 2'd1) || (operand != '0))) begin
			csr_model[addr[1:0]] = new_val;
		end
		if (rd != 5'd0) begin
			reg_model[rd] = old_val;
			expected.push_back({rd, old_val});
		end
	endtask

	task automatic check_wb();
		wb_t want;
		if (expected.size() == 0) begin
			$display("Writeback to x%0d with data %h came with nothing left to retire",
				wb.rd, wb.data);
			err_count++;
		end else begin
			want = expected.pop_front();
			if (wb.rd !== want.rd) begin
				$display("CHECK FAILED wb.rd expected %h got %h", want.rd, wb.rd);
				err_count++;
			end
			if (wb.data !== want.data) begin
				$display("CHECK FAILED wb.data expected %h got %h", want.data, wb.data);
				err_count++;
			end
		end
	endtask

	task automatic report_missing();
		foreach (expected[i]) begin
			$display("Expected writeback to x%0d with data %h never arrived",
				expected[i].rd, expected[i].data);
			err_count++;
		end
		reported = 1'b1;
	endtask

	always @(posedge CLK) begin
		if (!rst_n) begin
			foreach (csr_model[i]) begin
				csr_model[i] = '0;
			end
			foreach (reg_model[i]) begin
				reg_model[i] = '0;
			end
			queued_instr.delete();
			queued_pc.delete();
			expected.delete();
		end else begin
			if (flush) begin
				queued_instr.delete();
				queued_pc.delete();
			end
			if (instr_valid && is_csr(instr)) begin
				queued_instr.push_back(instr);
				queued_pc.push_back(instr_pc);
			end
			// x0 stays zero
			if (ext_wb_valid && (ext_wb.rd != 5'd0)) begin
				reg_model[ext_wb.rd] = ext_wb.data;
			end
			if (!flush && (queued_pc.size() != 0) && (queued_pc[0] == commit_pc)) begin
				retire(queued_instr.pop_front());
				void'(queued_pc.pop_front());
			end
			if (wb_valid) begin
				check_wb();
			end
			if (done && !reported) begin
				report_missing();
			end
		end
		n_pending = expected.size();
	end

endmodule

`default_nettype wire

/* tb/csr_unit_tb.sv */
//////////////////////////////////////////////////////////////////////
// Testbench for the CSR path
// Each table row strobes one instruction, with an optional external
// writeback, then holds commit_pc at its pc. commit_pc must stay
// there until two cycles after the strobe, longer while rs1 or rd
// is still pending. A late row keeps the previous commit_pc for one
// more cycle, so it overlaps the row before it. Rows with a hold of
// zero stay queued until a flush row drops them.
//////////////////////////////////////////////////////////////////////
`default_nettype none

module csr_unit_tb import csr_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int reset_cycles = 8;
	localparam logic [xlen-1:0] pc_base = 64'h1000;

	// funct3 codes of the Zicsr instructions
	localparam logic [2:0] fn_rw = 3'd1;
	localparam logic [2:0] fn_rs = 3'd2;
	localparam logic [2:0] fn_rc = 3'd3;
	localparam logic [2:0] fn_rwi = 3'd5;
	localparam logic [2:0] fn_rsi = 3'd6;
	localparam logic [2:0] fn_rci = 3'd7;
	localparam csr_addr_t csr_unknown = 12'h7c0;

	typedef struct packed {
		logic [31:0] instr;
		logic [xlen-1:0] pc;
		logic ext_en;
		reg_idx_t ext_rd;
		logic [7:0] hold;
		logic do_flush;
		logic late_commit;
	} row_t;

	logic CLK;
	logic rst_n;
	logic instr_valid;
	logic [31:0] instr;
	logic [xlen-1:0] instr_pc;
	logic [xlen-1:0] commit_pc;
	logic flush;
	logic ext_wb_valid;
	wb_t ext_wb;
	logic wb_valid;
	wb_t wb;
	logic done;
	int errors;
	int outstanding;

	row_t rows [$];
	logic [31:0] rng_state;

	csr_unit #(
		.FIFO_DEPTH(4)
	) uut (
		.CLK(CLK),
		.rst_n(rst_n),
		.instr_valid(instr_valid),
		.instr(instr),
		.instr_pc(instr_pc),
		.commit_pc(commit_pc),
		.flush(flush),
		.ext_wb_valid(ext_wb_valid),
		.ext_wb(ext_wb),
		.wb_valid(wb_valid),
		.wb(wb)
	);

	csr_unit_checker chk (
		.CLK(CLK),
		.rst_n(rst_n),
		.instr_valid(instr_valid),
		.instr(instr),
		.instr_pc(instr_pc),
		.commit_pc(commit_pc),
		.flush(flush),
		.ext_wb_valid(ext_wb_valid),
		.ext_wb(ext_wb),
		.wb_valid(wb_valid),
		.wb(wb),
		.done(done),
		.errors(errors),
		.outstanding(outstanding)
	);

	always #2 CLK = ~CLK;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Standard I-type layout of the SYSTEM opcode
	function automatic logic [31:0] csr_word(input logic [2:0] funct3, input reg_idx_t rd,
			input reg_idx_t rs1, input csr_addr_t addr);
		return {addr, rs1, funct3, rd, 7'b1110011};
	endfunction

	task automatic add_row(input logic [2:0] funct3, input reg_idx_t rd, input reg_idx_t rs1,
			input csr_addr_t addr, input logic ext_en, input reg_idx_t ext_rd,
			input int hold, input logic do_flush, input logic late_commit);
		row_t r;
		r.instr = csr_word(funct3, rd, rs1, addr);
		r.pc = pc_base + 64'(4 * rows.size());
		r.ext_en = ext_en;
		r.ext_rd = ext_rd;
		r.hold = 8'(hold);
		r.do_flush = do_flush;
		r.late_commit = late_commit;
		rows.push_back(r);
	endtask

	task automatic build_table();
		add_row(fn_rw, 5'd1, 5'd5, csr_mscratch, 1'b1, 5'd5, 3, 1'b0, 1'b0);
		add_row(fn_rw, 5'd2, 5'd6, csr_mepc, 1'b1, 5'd6, 3, 1'b0, 1'b0);
		add_row(fn_rw, 5'd3, 5'd7, csr_mcause, 1'b1, 5'd7, 4, 1'b0, 1'b0);
		add_row(fn_rw, 5'd4, 5'd8, csr_mtval, 1'b1, 5'd8, 3, 1'b0, 1'b0);
		// RAW chain through x9 and x10 that stalls on each result
		add_row(fn_rs, 5'd9, 5'd0, csr_mscratch, 1'b0, 5'd0, 2, 1'b0, 1'b0);
		add_row(fn_rw, 5'd10, 5'd9, csr_mepc, 1'b0, 5'd0, 3, 1'b0, 1'b1);
		add_row(fn_rs, 5'd11, 5'd10, csr_mcause, 1'b0, 5'd0, 4, 1'b0, 1'b1);
		add_row(fn_rc, 5'd13, 5'd12, csr_mcause, 1'b1, 5'd12, 3, 1'b0, 1'b0);
		add_row(fn_rc, 5'd14, 5'd0, csr_mcause, 1'b0, 5'd0, 3, 1'b0, 1'b0);
		add_row(fn_rwi, 5'd15, 5'h11, csr_mtval, 1'b0, 5'd0, 3, 1'b0, 1'b0);
		add_row(fn_rsi, 5'd16, 5'h0a, csr_mtval, 1'b0, 5'd0, 3, 1'b0, 1'b0);
		add_row(fn_rci, 5'd17, 5'h03, csr_mtval, 1'b0, 5'd0, 3, 1'b0, 1'b0);
		add_row(fn_rs, 5'd18, 5'd0, csr_mtval, 1'b0, 5'd0, 3, 1'b0, 1'b0);
		add_row(fn_rw, 5'd19, 5'd5, csr_unknown, 1'b0, 5'd0, 3, 1'b0, 1'b0);
		add_row(fn_rs, 5'd20, 5'd0, csr_unknown, 1'b0, 5'd0, 3, 1'b0, 1'b0);
		add_row(fn_rw, 5'd0, 5'd6, csr_mscratch, 1'b0, 5'd0, 3, 1'b0, 1'b0);
		add_row(fn_rs, 5'd21, 5'd0, csr_mscratch, 1'b0, 5'd0, 3, 1'b0, 1'b0);
		// Queued behind a stalled commit_pc, then flushed
		add_row(fn_rw, 5'd22, 5'd7, csr_mepc, 1'b0, 5'd0, 0, 1'b0, 1'b0);
		add_row(3'd0, 5'd3, 5'd0, 12'h000, 1'b0, 5'd0, 0, 1'b0, 1'b0);
		add_row(fn_rs, 5'd23, 5'd8, csr_mcause, 1'b0, 5'd0, 0, 1'b0, 1'b0);
		add_row(fn_rc, 5'd24, 5'd9, csr_mtval, 1'b0, 5'd0, 0, 1'b1, 1'b0);
		add_row(fn_rs, 5'd25, 5'd0, csr_mepc, 1'b0, 5'd0, 3, 1'b0, 1'b0);
		add_row(fn_rw, 5'd27, 5'd26, csr_mcause, 1'b1, 5'd26, 3, 1'b0, 1'b0);
		add_row(fn_rsi, 5'd28, 5'd0, csr_mscratch, 1'b0, 5'd0, 3, 1'b0, 1'b0);
		add_row(fn_rw, 5'd29, 5'd27, csr_mscratch, 1'b0, 5'd0, 3, 1'b0, 1'b0);
		add_row(fn_rw, 5'd30, 5'd22, csr_mepc, 1'b1, 5'd22, 3, 1'b0, 1'b0);
		add_row(fn_rw, 5'd31, 5'd29, csr_mscratch, 1'b0, 5'd0, 5, 1'b0, 1'b0);
		add_row(fn_rs, 5'd1, 5'd0, csr_mcause, 1'b0, 5'd0, 3, 1'b0, 1'b0);
		add_row(fn_rc, 5'd31, 5'd31, csr_mepc, 1'b0, 5'd0, 3, 1'b0, 1'b0);
	endtask

	task automatic apply_row(input row_t r);
		logic [31:0] hi;
		logic [31:0] lo;
		int n;
		int first;
		instr_valid <= 1'b1;
		instr <= r.instr;
		instr_pc <= r.pc;
		if (r.ext_en) begin
			rng_state = xorshift32(rng_state);
			hi = rng_state;
			rng_state = xorshift32(rng_state);
			lo = rng_state;
			ext_wb_valid <= 1'b1;
			ext_wb.rd <= r.ext_rd;
			ext_wb.data <= {hi, lo};
		end
		n = (r.hold > 8'd1) ? int'(r.hold) : 1;
		first = r.late_commit ? 1 : 0;
		for (int k = 0; k < n; k++) begin
			if ((r.hold != 8'd0) && (k == first)) begin
				commit_pc <= r.pc;
			end
			@(posedge CLK);
			instr_valid <= 1'b0;
			ext_wb_valid <= 1'b0;
		end
		if (r.do_flush) begin
			flush <= 1'b1;
			@(posedge CLK);
			flush <= 1'b0;
		end
	endtask

	initial begin
		CLK = 1'b0;
		rst_n = 1'b0;
		instr_valid = 1'b0;
		instr = '0;
		instr_pc = '0;
		commit_pc = '0;
		flush = 1'b0;
		ext_wb_valid = 1'b0;
		ext_wb = '0;
		rng_state = 32'h3e62;
		build_table();
		repeat (reset_cycles) @(posedge CLK);
		rst_n <= 1'b1;
		@(posedge CLK);
		foreach (rows[i]) begin
			apply_row(rows[i]);
		end
		wait (outstanding == 0);
		// Quiet tail to catch stray writebacks
		repeat (8) @(posedge CLK);
		$display("Applied %0d rows, %0d errors", rows.size(), errors);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	// About 20 cycles per row plus reset
	initial begin
		int limit;
		done = 1'b0;
		@(posedge CLK);
		limit = rows.size() * 20 + reset_cycles;
		repeat (limit) @(posedge CLK);
		$display("Timeout after %0d cycles with %0d writebacks still missing", limit,
			outstanding);
		done <= 1'b1;
		repeat (2) @(posedge CLK);
		$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire
